// ==== led_panel.f ====
verilog/led_panel_pkg.sv
verilog/scan_counter.sv
verilog/frame_buffer.sv
verilog/pwm_slice.sv
verilog/panel_scanner.sv
verilog/led_panel_top.sv
sim/clock_gen.sv
sim/led_panel_asserts.sv
sim/tb_led_panel.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_led_panel
FILELIST  ?= led_panel.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/led_panel_golden.txt ====
# op  address (hex: bank bit, row, column)  data (hex)
# T <name> starts a test, W writes, R reads and expects the data
T write_read_top
W 000 f800
R 000 f800
W 7c5 07e0
R 7c5 07e0
T write_read_bottom
W 800 001f
R 800 001f
W fff abcd
R fff abcd
T bank_isolation
W 123 1111
W 923 2222
R 123 1111
R 923 2222
W 123 3333
R 923 2222
R 123 3333
T zero_pixel
W 456 0000
R 456 0000
R 555 0000

// ==== sim/tb_led_panel.sv ====
`default_nettype none

module tb_led_panel;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT    = 100000;
    localparam int WATCH_ROWS = 256;
    localparam int PIXELS     = 4096;   // both banks

    logic                   clk;
    logic                   pll_locked;
    led_panel_pkg::wb_req_t wb_req;
    led_panel_pkg::wb_rsp_t wb_rsp;
    led_panel_pkg::panel_t  panel;
    int                     error_count;
    int                     timeout_count;
    logic [8*32-1:0]        test_name;

    logic       prev_sclk;
    logic       prev_latch;
    logic [4:0] prev_addr;
    int         sclk_count;
    int         latch_count;

    clock_gen u_clk (
        .clk        (clk),
        .pll_locked (pll_locked)
    );

    led_panel_top u_dut (
        .clk        (clk),
        .pll_locked (pll_locked),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .panel      (panel)
    );

    bind panel_scanner led_panel_asserts u_scan_asserts (
        .clk(clk), .pll_locked(pll_locked), .ack(1'b0),
        .blank(panel.blank), .latch(panel.latch), .sclk(panel.sclk)
    );

    bind frame_buffer led_panel_asserts u_buf_asserts (
        .clk(clk), .pll_locked(pll_locked), .ack(wb_rsp.ack),
        .blank(1'b1), .latch(1'b0), .sclk(1'b0)
    );

    // row rhythm and address order, runs for the whole simulation
    always @(posedge clk) begin
        if (!pll_locked) begin
            sclk_count  = 0;
            latch_count = 0;
        end else begin
            if (panel.sclk && !prev_sclk) sclk_count++;
            if (panel.latch && !prev_latch) begin
                if (latch_count > 0 && sclk_count != 64) begin
                    $display("error: test panel_scan expected %0d actual %0d", 64, sclk_count);
                    error_count++;
                end
                sclk_count = 0;
                latch_count++;
            end
            if (panel.addr != prev_addr) begin
                if (!panel.blank) begin
                    $display("panel addr changed while blank was low");
                    error_count++;
                end
                if (panel.addr != 5'(prev_addr + 5'd1)) begin
                    $display("error: test panel_addr expected %0d actual %0d",
                             5'(prev_addr + 5'd1), panel.addr);
                    error_count++;
                end
            end
        end
        prev_sclk  = panel.sclk;
        prev_latch = panel.latch;
        prev_addr  = panel.addr;
    end

    task automatic report_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, TIMEOUT);
        timeout_count++;
    endtask

    // one classic cycle, held until ack, then a random gap
    task automatic wb_access(input logic write, input logic [11:0] adr,
                             input logic [15:0] dat, output logic [15:0] rdata);
        int   cnt;
        logic got;
        cnt   = 0;
        got   = 1'b0;
        rdata = 'x;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: write, adr: adr, dat: dat};
        while (!got && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
            if (wb_rsp.ack) got = 1'b1;
        end
        if (!got) begin
            report_timeout("wishbone ack");
        end else begin
            rdata = wb_rsp.dat;
        end
        wb_req <= '0;
        repeat ($urandom_range(3, 0)) @(posedge clk);
    endtask

    task automatic fill_panel(input logic [15:0] colour);
        logic [15:0] rd;
        for (int a = 0; a < PIXELS && timeout_count == 0; a++) begin
            wb_access(1'b1, 12'(a), colour, rd);
        end
    endtask

    // collects the shifted rgb bits over a number of rows
    task automatic watch_rows(input logic expect_lit);
        logic [5:0] seen;
        int         rows;
        int         cnt;
        logic       pl;
        logic       ps;
        seen = '0;
        rows = 0;
        cnt  = 0;
        pl   = panel.latch;
        ps   = panel.sclk;
        while (rows < WATCH_ROWS && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
            if (panel.sclk && !ps) seen = seen | {panel.rgb_top, panel.rgb_bot};
            if (panel.latch && !pl) rows++;
            pl = panel.latch;
            ps = panel.sclk;
        end
        if (rows < WATCH_ROWS) begin
            report_timeout("complete set of rows");
        end else if (seen != (expect_lit ? 6'h3f : 6'h00)) begin
            $display("error: test %0s expected %h actual %h",
                     test_name, (expect_lit ? 6'h3f : 6'h00), seen);
            error_count++;
        end
    endtask

    task automatic run_golden();
        int              fd;
        int              n;
        string           line;
        logic [8*8-1:0]  tok;
        logic [11:0]     adr;
        logic [15:0]     dat;
        logic [15:0]     rd;
        fd = $fopen("sim/led_panel_golden.txt", "r");
        if (fd == 0) begin
            $display("golden file could not be opened");
            error_count++;
            return;
        end
        while (!$feof(fd) && timeout_count == 0) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                n = $sscanf(line, "%s", tok);
                if (tok == "T") begin
                    n = $sscanf(line, "%s %s", tok, test_name);
                end else if ($sscanf(line, "%s %h %h", tok, adr, dat) != 3) begin
                    $display("golden line could not be parsed: %s", line);
                    error_count++;
                end else if (tok == "W") begin
                    wb_access(1'b1, adr, dat, rd);
                end else begin
                    wb_access(1'b0, adr, 16'h0000, rd);
                    if (timeout_count == 0 && rd !== dat) begin
                        $display("error: test %0s addr %h expected %h actual %h",
                                 test_name, adr, dat, rd);
                        error_count++;
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int cnt;
        wb_req        = '0;
        error_count   = 0;
        timeout_count = 0;
        test_name     = "reset";
        cnt           = 0;
        void'($urandom(39));

        while (!pll_locked && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (!pll_locked) begin
            report_timeout("release of pll_locked");
        end else if (panel.blank !== 1'b1 || panel.latch !== 1'b0 || panel.sclk !== 1'b0) begin
            $display("error: test %0s expected %b actual %b", test_name,
                     3'b100, {panel.blank, panel.latch, panel.sclk});
            error_count++;
        end

        test_name = "dark_panel";
        fill_panel(16'h0000);
        if (timeout_count == 0) begin
            watch_rows(1'b0);
        end

        run_golden();

        test_name = "white_panel";
        fill_panel(16'hffff);
        if (timeout_count == 0) begin
            watch_rows(1'b1);
        end

        $display("errors: %0d timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/led_panel_asserts.sv ====
`default_nettype none

module led_panel_asserts (
    input wire clk,
    input wire pll_locked,
    input wire ack,
    input wire blank,
    input wire latch,
    input wire sclk
);
    timeunit 1ns;
    timeprecision 100ps;

    // bus handshake
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!pll_locked) $rose(ack) |=> !ack
    ) else $error("ack held for more than one cycle");

    // row latch only on a dark panel
    latch_while_blank: assert property (
        @(posedge clk) disable iff (!pll_locked) $rose(latch) |-> blank
    ) else $error("latch rose while blank was low");

    no_shift_in_latch: assert property (
        @(posedge clk) disable iff (!pll_locked) $rose(sclk) |-> !(latch && blank)
    ) else $error("sclk rose during the latch cycle");

endmodule

`default_nettype wire

// ==== sim/clock_gen.sv ====
`default_nettype none

module clock_gen (
    output logic clk,
    output logic pll_locked
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;
    always #2 clk = ~clk;   // 4 ns period

    // lock comes up on a falling edge, away from the sampling edge
    initial begin
        pll_locked = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        pll_locked = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/led_panel_top.sv ====
`default_nettype none

module led_panel_top (
    input  wire                        clk,
    input  wire                        pll_locked,
    input  wire led_panel_pkg::wb_req_t   wb_req,
    output led_panel_pkg::wb_rsp_t     wb_rsp,
    output led_panel_pkg::panel_t      panel
);

    localparam int HALF = led_panel_pkg::RGB_BITS / 2;

    led_panel_pkg::scan_pos_t            pos;
    led_panel_pkg::pixel_pair_t          pixels;
    logic                                steal;
    logic                                col_step;
    logic [led_panel_pkg::RGB_BITS-1:0]  rgb;      // top r g b, then bottom r g b

    scan_counter u_counter (
        .clk        (clk),
        .pll_locked (pll_locked),
        .col_step   (col_step),
        .pos        (pos),
        .steal      (steal)
    );

    frame_buffer u_buffer (
        .clk        (clk),
        .pll_locked (pll_locked),
        .pos        (pos),
        .steal      (steal),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .pixels     (pixels)
    );

    for (genvar i = 0; i < led_panel_pkg::RGB_BITS; i++) begin : g_slice
        localparam int CH = i % HALF;     // red, green, blue in that order
        localparam int W  = (CH == 0) ? $bits(pixels.top.r) :
                            (CH == 1) ? $bits(pixels.top.g) : $bits(pixels.top.b);

        led_panel_pkg::pixel_t px;
        logic [W-1:0]          chan;

        assign px = (i < HALF) ? pixels.top : pixels.bottom;

        if (CH == 0) begin : g_red
            assign chan = px.r;
        end else if (CH == 1) begin : g_green
            assign chan = px.g;
        end else begin : g_blue
            assign chan = px.b;
        end

        pwm_slice #(
            .CHANNEL_BITS (W)
        ) u_slice (
            .clk        (clk),
            .pll_locked (pll_locked),
            .subframe   (pos.subframe),
            .channel    (chan),
            .lit        (rgb[led_panel_pkg::RGB_BITS-1-i])
        );
    end

    panel_scanner u_scanner (
        .clk        (clk),
        .pll_locked (pll_locked),
        .rgb        (rgb),
        .row        (pos.row),
        .col_step   (col_step),
        .panel      (panel)
    );

endmodule

`default_nettype wire

// ==== verilog/panel_scanner.sv ====
`default_nettype none

module panel_scanner (
    input  wire                                 clk,
    input  wire                                 pll_locked,
    input  wire [led_panel_pkg::RGB_BITS-1:0]   rgb,
    input  wire [led_panel_pkg::ROW_BITS-1:0]   row,
    output logic                                col_step,
    output led_panel_pkg::panel_t               panel
);

    localparam int HALF = led_panel_pkg::RGB_BITS / 2;

    typedef enum logic [1:0] {
        ST_SHIFT,
        ST_BLANK,
        ST_LATCH,
        ST_UNBLANK
    } state_t;

    state_t                             state;
    logic                               phase;      // high while sclk is high
    logic [led_panel_pkg::COL_BITS-1:0] col;        // column on the panel pins
    logic [led_panel_pkg::ROW_BITS-1:0] shift_row;  // row pair being shifted
    logic                               last_col;

    assign last_col = &col;

    // fetch runs two columns ahead of the pins
    // the fetch for column 1 waits until the latch cycle so that
    // column 0 of the next row is still on rgb at unblank
    assign col_step = (state == ST_LATCH) || (state == ST_SHIFT && !phase && !last_col);

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            state     <= ST_BLANK;
            phase     <= 1'b0;
            col       <= '0;
            shift_row <= '0;
            panel     <= '{blank: 1'b1, default: '0};
        end else begin
            case (state)
                ST_SHIFT: begin
                    phase <= !phase;
                    if (!phase) begin
                        panel.sclk <= 1'b1;     // data has had a cycle to settle
                    end else begin
                        panel.sclk <= 1'b0;
                        if (last_col) begin
                            panel.blank <= 1'b1;
                            state       <= ST_BLANK;
                        end else begin
                            col           <= col + 1'b1;
                            panel.rgb_top <= rgb[led_panel_pkg::RGB_BITS-1:HALF];
                            panel.rgb_bot <= rgb[HALF-1:0];
                        end
                    end
                end

                ST_BLANK: begin
                    panel.latch <= 1'b1;
                    state       <= ST_LATCH;
                end

                ST_LATCH: begin
                    panel.latch <= 1'b0;
                    panel.addr  <= shift_row;   // address moves while still dark
                    state       <= ST_UNBLANK;
                end

                ST_UNBLANK: begin
                    panel.blank   <= 1'b0;
                    panel.rgb_top <= rgb[led_panel_pkg::RGB_BITS-1:HALF];
                    panel.rgb_bot <= rgb[HALF-1:0];
                    col           <= '0;
                    shift_row     <= row;       // counter already sits on the next row
                    phase         <= 1'b0;
                    state         <= ST_SHIFT;
                end

                default: begin
                    state <= ST_BLANK;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pwm_slice.sv ====
`default_nettype none

module pwm_slice #(
    parameter int CHANNEL_BITS = 5
) (
    input  wire                                     clk,
    input  wire                                     pll_locked,
    input  wire [led_panel_pkg::SUBFRAME_BITS-1:0]  subframe,
    input  wire [CHANNEL_BITS-1:0]                  channel,
    output logic                                    lit
);

    localparam int SB = led_panel_pkg::SUBFRAME_BITS;

    logic [SB-1:0] level;
    logic [SB-1:0] threshold;

    // scale up to 8 bits by padding on the right
    assign level = {channel, {(SB - CHANNEL_BITS){1'b0}}};

    // reversed subframe spreads the on time, less visible flicker
    always_comb begin
        for (int i = 0; i < SB; i++) begin
            threshold[i] = subframe[SB-1-i];
        end
    end

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            lit <= 1'b0;
        end else begin
            lit <= level > threshold;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/frame_buffer.sv ====
`default_nettype none

module frame_buffer (
    input  wire                        clk,
    input  wire                        pll_locked,
    input  wire led_panel_pkg::scan_pos_t pos,
    input  wire                        steal,
    input  wire led_panel_pkg::wb_req_t   wb_req,
    output led_panel_pkg::wb_rsp_t     wb_rsp,
    output led_panel_pkg::pixel_pair_t pixels
);

    localparam int ADDR_BITS = $bits(led_panel_pkg::fb_addr_t);
    localparam int DEPTH     = 1 << ADDR_BITS;

    led_panel_pkg::pixel_t mem_top [DEPTH];     // panel rows 0 to 31
    led_panel_pkg::pixel_t mem_bot [DEPTH];     // panel rows 32 to 63

    led_panel_pkg::fb_addr_t addr;
    led_panel_pkg::pixel_t   rd_top;
    led_panel_pkg::pixel_t   rd_bot;
    logic                    wb_bank;
    logic                    wb_go;
    logic                    ack_q;
    logic                    bank_q;
    logic                    dark_q;

    assign wb_bank = wb_req.adr[ADDR_BITS];

    // ack_q holds off a second access while the master drops stb
    assign wb_go = steal && wb_req.cyc && wb_req.stb && !ack_q;

    // bus owns the address during a stolen subframe
    assign addr = steal ? wb_req.adr[ADDR_BITS-1:0] : {pos.row, pos.col};

    always_ff @(posedge clk) begin
        if (wb_go && wb_req.we && !wb_bank) begin
            mem_top[addr] <= wb_req.dat;
        end
        rd_top <= mem_top[addr];
    end

    always_ff @(posedge clk) begin
        if (wb_go && wb_req.we && wb_bank) begin
            mem_bot[addr] <= wb_req.dat;
        end
        rd_bot <= mem_bot[addr];
    end

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            ack_q  <= 1'b0;
            bank_q <= 1'b0;
            dark_q <= 1'b0;
        end else begin
            ack_q  <= wb_go;        // single cycle, read data arrives with it
            bank_q <= wb_bank;
            dark_q <= steal;        // lines up with the registered read
        end
    end

    always_comb begin
        wb_rsp.ack = ack_q;
        wb_rsp.dat = bank_q ? rd_bot : rd_top;
    end

    always_comb begin
        pixels.top    = rd_top;
        pixels.bottom = rd_bot;
        if (dark_q) begin
            pixels = '0;    // panel stays dark while the bus has the memory
        end
    end

endmodule

`default_nettype wire

// ==== verilog/scan_counter.sv ====
`default_nettype none

module scan_counter (
    input  wire                      clk,
    input  wire                      pll_locked,
    input  wire                      col_step,
    output led_panel_pkg::scan_pos_t pos,
    output logic                     steal
);

    logic col_wrap;
    logic row_wrap;

    assign col_wrap = &pos.col;
    assign row_wrap = &pos.row;

    // column is the fast digit, subframe the slow one
    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            pos <= '0;
        end else if (col_step) begin
            pos.col <= pos.col + 1'b1;
            if (col_wrap) begin
                pos.row <= pos.row + 1'b1;
                if (row_wrap) begin
                    pos.subframe <= pos.subframe + 1'b1;   // wraps after 256
                end
            end
        end
    end

    // every sixteenth subframe is dark and belongs to the bus
    assign steal = &pos.subframe[led_panel_pkg::STEAL_BITS-1:0];

endmodule

`default_nettype wire

// ==== verilog/led_panel_pkg.sv ====
`default_nettype none

package led_panel_pkg;

    localparam int COL_BITS      = 6;   // 64 columns per row
    localparam int ROW_BITS      = 5;   // 32 row pairs, both halves scanned together
    localparam int SUBFRAME_BITS = 8;   // pwm resolution
    localparam int STEAL_BITS    = 4;   // one subframe in sixteen goes to the bus
    localparam int RGB_BITS      = 6;   // three colours for each half
    localparam int WB_ADR_BITS   = 1 + ROW_BITS + COL_BITS;
    localparam int WB_DAT_BITS   = 16;

    // address inside one bank, row above column
    typedef logic [ROW_BITS+COL_BITS-1:0] fb_addr_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } pixel_t;          // rgb565

    typedef struct packed {
        pixel_t top;
        pixel_t bottom;
    } pixel_pair_t;

    typedef struct packed {
        logic [SUBFRAME_BITS-1:0] subframe;
        logic [ROW_BITS-1:0]      row;
        logic [COL_BITS-1:0]      col;
    } scan_pos_t;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [WB_ADR_BITS-1:0] adr;    // bank select on top
        logic [WB_DAT_BITS-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic [WB_DAT_BITS-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [RGB_BITS/2-1:0] rgb_top;
        logic [RGB_BITS/2-1:0] rgb_bot;
        logic [ROW_BITS-1:0]   addr;
        logic                  blank;
        logic                  latch;
        logic                  sclk;
    } panel_t;

endpackage

`default_nettype wire
